//--- files.f
rtl/cache_pkg.sv
rtl/mem_pkg.sv
rtl/cache_ifs.sv
rtl/cache_ctrl.sv
rtl/data_array.sv
rtl/fill_merge.sv
rtl/mem_link.sv
rtl/l1_cache_top.sv
test/l2_model.sv
test/tb_l1_cache.sv

//--- rtl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           req_valid,
    input  cache_pkg::cpu_op_t             req_op,
    input  logic [cache_pkg::ADDR_W-1:0]   req_addr,
    input  logic                           flush,
    input  logic                           mem_resp_valid,
    output logic                           stall,
    output logic                           resp_valid,
    array_if.ctrl                          arr,
    mem_req_if.ctrl                        mreq
);
    import cache_pkg::*;
    import mem_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]   tag_mem [0:SETS-1];
    logic [SETS-1:0]    valid_bits;
    logic [SETS-1:0]    dirty_bits;
    ctrl_state_t        state;
    ctrl_state_t        next_state;
    cpu_op_t            op_q;
    logic [TAG_W-1:0]   tag_q;
    logic [INDEX_W-1:0] idx_q;
    logic               refill_sent;
    logic               hit;
    logic               victim_dirty;
    logic               issue;
    logic               refill_done;

    assign hit          = valid_bits[idx_q] && (tag_mem[idx_q] == tag_q);
    assign victim_dirty = valid_bits[idx_q] && dirty_bits[idx_q];
    assign issue        = mreq.valid && mreq.ready;
    assign refill_done  = (state == ST_ALLOCATE) && refill_sent && mem_resp_valid;
    assign stall        = (state != ST_IDLE);

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
                if (req_valid)
                    next_state = ST_COMPARE;
            ST_COMPARE:
                if (hit)
                    next_state = ST_IDLE;
                else if (victim_dirty)
                    next_state = ST_WRITE_BACK;
                else
                    next_state = ST_ALLOCATE;
            // held here while no credit is left
            ST_WRITE_BACK:
                if (issue)
                    next_state = ST_ALLOCATE;
            ST_ALLOCATE:
                if (refill_done)
                    next_state = ST_IDLE;
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    // accepted request
    always_ff @(posedge clk)
    begin
        if ((state == ST_IDLE) && req_valid)
        begin
            op_q  <= req_op;
            tag_q <= req_addr[INDEX_W +: TAG_W];
            idx_q <= req_addr[INDEX_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            refill_sent <= 1'b0;
        else if (refill_done)
            refill_sent <= 1'b0;
        else if ((state == ST_ALLOCATE) && issue)
            refill_sent <= 1'b1;
    end

    // flush drops dirty lines without write-back
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end
        else if ((state == ST_IDLE) && flush)
        begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end
        else if ((state == ST_COMPARE) && hit && (op_q == CPU_WRITE))
            dirty_bits[idx_q] <= 1'b1;
        else if (refill_done)
        begin
            valid_bits[idx_q] <= 1'b1;
            dirty_bits[idx_q] <= (op_q == CPU_WRITE);
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill_done)
            tag_mem[idx_q] <= tag_q;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            resp_valid <= 1'b0;
        else
            resp_valid <= ((state == ST_COMPARE) && hit) || refill_done;
    end

    // store data on writes, refill word on read misses
    assign arr.rd_index = idx_q;
    assign arr.wr_index = idx_q;
    assign arr.wr_en    = ((state == ST_COMPARE) && hit && (op_q == CPU_WRITE)) || refill_done;
    assign arr.fill_sel = (op_q == CPU_READ);

    assign mreq.valid = (state == ST_WRITE_BACK) || ((state == ST_ALLOCATE) && !refill_sent);
    assign mreq.op    = (state == ST_WRITE_BACK) ? MEM_WRITE_BACK : MEM_REFILL_READ;
    // victim address on write-back
    assign mreq.addr  = (state == ST_WRITE_BACK) ? {tag_mem[idx_q], idx_q} : {tag_q, idx_q};
    assign mreq.wdata = arr.rd_data;

endmodule

//--- rtl/cache_ifs.sv
`timescale 1ns/1ps

// controller to data array and fill merge
interface array_if;
    import cache_pkg::*;

    logic [INDEX_W-1:0] rd_index;
    logic               wr_en;
    logic [INDEX_W-1:0] wr_index;
    logic               fill_sel;
    logic [DATA_W-1:0]  wr_data;
    logic [DATA_W-1:0]  rd_data;

    // rd_data also feeds the write-back payload
    modport ctrl (output rd_index, output wr_en, output wr_index, output fill_sel,
                  input rd_data);
    modport array (input rd_index, input wr_en, input wr_index, input wr_data,
                   output rd_data);
    modport merge (input fill_sel, input rd_data, output wr_data);
endinterface

// controller to L2 link with transfer on valid && ready
interface mem_req_if;
    import cache_pkg::*;
    import mem_pkg::*;

    logic                  valid;
    mem_op_t               op;
    logic [MEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
    logic                  ready;

    modport ctrl (output valid, output op, output addr, output wdata, input ready);
    modport link (input valid, input op, input addr, input wdata, output ready);
endinterface

//--- rtl/cache_pkg.sv
package cache_pkg;

    // word address is [31:26] unused, [25:6] tag and [5:0] index
    localparam int ADDR_W  = 32;
    localparam int TAG_W   = 20;
    localparam int INDEX_W = 6;
    localparam int DATA_W  = 32;

    typedef enum logic [1:0]
    {
        ST_IDLE       = 2'b00,
        ST_COMPARE    = 2'b01,
        ST_WRITE_BACK = 2'b10,
        ST_ALLOCATE   = 2'b11
    } ctrl_state_t;

    typedef enum logic
    {
        CPU_READ  = 1'b0,
        CPU_WRITE = 1'b1
    } cpu_op_t;

endpackage

//--- rtl/data_array.sv
`timescale 1ns/1ps

module data_array (
    input  logic    clk,
    array_if.array  arr
);
    import cache_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    logic [DATA_W-1:0] words [0:SETS-1];

    always_ff @(posedge clk)
    begin
        if (arr.wr_en)
            words[arr.wr_index] <= arr.wr_data;
    end

    // read is combinational so the victim word is ready in compare
    assign arr.rd_data = words[arr.rd_index];

endmodule

//--- rtl/fill_merge.sv
`timescale 1ns/1ps

module fill_merge (
    input  logic [cache_pkg::DATA_W-1:0]  req_wdata,
    input  logic [cache_pkg::DATA_W-1:0]  mem_resp_rdata,
    output logic [cache_pkg::DATA_W-1:0]  resp_rdata,
    array_if.merge                        arr
);
    import cache_pkg::*;

    logic [DATA_W-1:0] fill_word;

    // one word per line so the refill word replaces the whole line
    assign fill_word = mem_resp_rdata;

    // req_wdata is held by the processor while stall is high
    always_comb
    begin
        if (arr.fill_sel)
            arr.wr_data = fill_word;
        else
            arr.wr_data = req_wdata;
    end

    // array was written the cycle before resp_valid so for writes this is the stored word
    assign resp_rdata = arr.rd_data;

endmodule

//--- rtl/l1_cache_top.sv
`timescale 1ns/1ps

module l1_cache_top #(
    parameter int L2_CREDITS = 2
) (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             req_valid,
    input  cache_pkg::cpu_op_t               req_op,
    input  logic [cache_pkg::ADDR_W-1:0]     req_addr,
    input  logic [cache_pkg::DATA_W-1:0]     req_wdata,
    input  logic                             flush,
    output logic                             stall,
    output logic                             resp_valid,
    output logic [cache_pkg::DATA_W-1:0]     resp_rdata,
    output logic                             mem_req_valid,
    output mem_pkg::mem_op_t                 mem_req_op,
    output logic [mem_pkg::MEM_ADDR_W-1:0]   mem_req_addr,
    output logic [cache_pkg::DATA_W-1:0]     mem_req_wdata,
    input  logic                             mem_credit,
    input  logic                             mem_resp_valid,
    input  logic [cache_pkg::DATA_W-1:0]     mem_resp_rdata
);

    array_if   u_arr_if ();
    mem_req_if u_mreq_if ();

    cache_ctrl u_ctrl (
        .clk            (clk),
        .nrst           (nrst),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .flush          (flush),
        .mem_resp_valid (mem_resp_valid),
        .stall          (stall),
        .resp_valid     (resp_valid),
        .arr            (u_arr_if.ctrl),
        .mreq           (u_mreq_if.ctrl)
    );

    data_array u_data (
        .clk (clk),
        .arr (u_arr_if.array)
    );

    fill_merge u_merge (
        .req_wdata      (req_wdata),
        .mem_resp_rdata (mem_resp_rdata),
        .resp_rdata     (resp_rdata),
        .arr            (u_arr_if.merge)
    );

    mem_link #(
        .L2_CREDITS (L2_CREDITS)
    ) u_link (
        .clk           (clk),
        .nrst          (nrst),
        .mem_credit    (mem_credit),
        .mem_req_valid (mem_req_valid),
        .mem_req_op    (mem_req_op),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mreq          (u_mreq_if.link)
    );

endmodule

//--- rtl/mem_link.sv
`timescale 1ns/1ps

module mem_link #(
    parameter int L2_CREDITS = 2
) (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             mem_credit,
    output logic                             mem_req_valid,
    output mem_pkg::mem_op_t                 mem_req_op,
    output logic [mem_pkg::MEM_ADDR_W-1:0]   mem_req_addr,
    output logic [cache_pkg::DATA_W-1:0]     mem_req_wdata,
    mem_req_if.link                          mreq
);
    import mem_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic                issue;

    assign mreq.ready = (credits != '0);
    assign issue      = mreq.valid && mreq.ready;

    // spend and return may land in the same cycle
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            credits <= CREDIT_W'(L2_CREDITS);
        else
        begin
            case ({issue, mem_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            mem_req_valid <= 1'b0;
        else
            mem_req_valid <= issue;
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            mem_req_op    <= mreq.op;
            mem_req_addr  <= mreq.addr;
            mem_req_wdata <= mreq.wdata;
        end
    end

endmodule

//--- rtl/mem_pkg.sv
package mem_pkg;

    // line address toward L2 is tag plus index
    localparam int MEM_ADDR_W = 26;

    // wide enough for up to 7 credits
    localparam int CREDIT_W = 3;

    typedef enum logic
    {
        MEM_REFILL_READ = 1'b0,
        MEM_WRITE_BACK  = 1'b1
    } mem_op_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the L1 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_l1_cache -o sim_l1_cache
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_l1_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
exit 1

//--- test/l2_model.sv
`timescale 1ns/1ps

module l2_model (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           mem_req_valid,
    input  mem_pkg::mem_op_t               mem_req_op,
    input  logic [mem_pkg::MEM_ADDR_W-1:0] mem_req_addr,
    input  logic [31:0]                    mem_req_wdata,
    output logic                           mem_credit,
    output logic                           mem_resp_valid,
    output logic [31:0]                    mem_resp_rdata
);
    import mem_pkg::*;

    logic [31:0] mem [logic [MEM_ADDR_W-1:0]];
    int          credit_due [$];
    int          resp_due [$];
    logic [31:0] resp_data [$];
    int          cyc;
    int          last_resp;

    // untouched locations hold a pattern of the full line address
    function automatic logic [31:0] fill_word(input logic [MEM_ADDR_W-1:0] addr);
        fill_word = {addr[15:0], addr[25:10]} ^ {6'h2b, addr};
    endfunction

    initial
    begin
        int due;
        void'($urandom(94));
        cyc            = 0;
        last_resp      = 0;
        mem_credit     = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
        forever
        begin
            @(posedge clk);
            cyc++;
            mem_credit     <= 1'b0;
            mem_resp_valid <= 1'b0;
            if (nrst && mem_req_valid)
            begin
                credit_due.push_back(cyc + 1 + int'($urandom % 6));
                if (mem_req_op == MEM_WRITE_BACK)
                    mem[mem_req_addr] = mem_req_wdata;
                else
                begin
                    // responses stay in request order
                    due = cyc + 1 + int'($urandom % 6);
                    if (due <= last_resp)
                        due = last_resp + 1;
                    last_resp = due;
                    resp_due.push_back(due);
                    if (mem.exists(mem_req_addr))
                        resp_data.push_back(mem[mem_req_addr]);
                    else
                        resp_data.push_back(fill_word(mem_req_addr));
                end
            end
            // one credit per cycle at most
            if ((credit_due.size() != 0) && (credit_due[0] <= cyc))
            begin
                void'(credit_due.pop_front());
                mem_credit <= 1'b1;
            end
            if ((resp_due.size() != 0) && (resp_due[0] <= cyc))
            begin
                void'(resp_due.pop_front());
                mem_resp_valid <= 1'b1;
                mem_resp_rdata <= resp_data.pop_front();
            end
        end
    end

endmodule

//--- test/tb_l1_cache.sv
`timescale 1ns/1ps

module tb_l1_cache;
    import cache_pkg::*;
    import mem_pkg::*;

    logic                  clk;
    logic                  nrst;
    logic                  req_valid;
    cpu_op_t               req_op;
    logic [31:0]           req_addr;
    logic [31:0]           req_wdata;
    logic                  flush;
    logic                  stall;
    logic                  resp_valid;
    logic [31:0]           resp_rdata;
    logic                  mem_req_valid;
    mem_op_t               mem_req_op;
    logic [MEM_ADDR_W-1:0] mem_req_addr;
    logic [31:0]           mem_req_wdata;
    logic                  mem_credit;
    logic                  mem_resp_valid;
    logic [31:0]           mem_resp_rdata;

    // reference cache and expected L2 contents
    logic [TAG_W-1:0]      line_tag [0:63];
    logic [31:0]           line_data [0:63];
    logic [63:0]           line_valid;
    logic [63:0]           line_dirty;
    logic [31:0]           l2_exp [logic [MEM_ADDR_W-1:0]];

    // expectations for the request in flight
    logic                  exp_hit;
    logic                  exp_dirty;
    logic [MEM_ADDR_W-1:0] exp_line;
    logic [MEM_ADDR_W-1:0] exp_wb_addr;
    logic [31:0]           exp_wb_data;
    logic [31:0]           exp_rdata;
    mem_op_t               exp_mem_op;
    logic [MEM_ADDR_W-1:0] exp_mem_addr;
    logic                  accept;
    logic                  seen_req;
    int                    mem_seq;
    int                    outstanding;
    int                    err_count;
    int                    issued;
    int                    wd_cycles;

    l1_cache_top #(
        .L2_CREDITS (2)
    ) u_dut (
        .clk            (clk),
        .nrst           (nrst),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .flush          (flush),
        .stall          (stall),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_op     (mem_req_op),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .mem_credit     (mem_credit),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata)
    );

    l2_model u_l2 (
        .clk            (clk),
        .nrst           (nrst),
        .mem_req_valid  (mem_req_valid),
        .mem_req_op     (mem_req_op),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .mem_credit     (mem_credit),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata)
    );

    always #5 clk = ~clk;

    assign accept       = req_valid && !stall;
    // a dirty victim goes out first
    assign exp_mem_op   = (exp_dirty && (mem_seq == 0)) ? MEM_WRITE_BACK : MEM_REFILL_READ;
    assign exp_mem_addr = (exp_dirty && (mem_seq == 0)) ? exp_wb_addr : exp_line;

    always @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            mem_seq     <= 0;
            outstanding <= 0;
            seen_req    <= 1'b0;
        end
        else
        begin
            if (accept)
                mem_seq <= 0;
            else if (mem_req_valid)
                mem_seq <= mem_seq + 1;
            outstanding <= outstanding + int'(mem_req_valid) - int'(mem_credit);
            if (req_valid)
                seen_req <= 1'b1;
        end
    end

    function automatic logic [31:0] fill_word(input logic [MEM_ADDR_W-1:0] addr);
        fill_word = {addr[15:0], addr[25:10]} ^ {6'h2b, addr};
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        err_count++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("failure at %0t: %s", $time, what);
    endtask

    idle_before_first_req: assert property (@(posedge clk) disable iff (!nrst)
        !seen_req |-> (!stall && !resp_valid && !mem_req_valid))
        else report_failure("stall, resp_valid or mem_req_valid high before the first request");
    resp_data_check: assert property (@(posedge clk) disable iff (!nrst)
        resp_valid |-> (resp_rdata == exp_rdata))
        else log_mismatch("resp_rdata", resp_rdata, exp_rdata);
    hit_latency_check: assert property (@(posedge clk) disable iff (!nrst)
        $past(accept, 2) |-> (resp_valid == exp_hit))
        else log_mismatch("resp_valid", 32'(resp_valid), 32'(exp_hit));
    hit_stall_check: assert property (@(posedge clk) disable iff (!nrst)
        ($past(accept, 2) && exp_hit) |-> !stall)
        else report_failure("stall still high when a hit responds");
    no_l2_on_hit: assert property (@(posedge clk) disable iff (!nrst)
        mem_req_valid |-> !exp_hit)
        else report_failure("L2 request issued for a hit");
    mem_op_check: assert property (@(posedge clk) disable iff (!nrst)
        mem_req_valid |-> (mem_req_op == exp_mem_op))
        else log_mismatch("mem_req_op", 32'(mem_req_op), 32'(exp_mem_op));
    mem_addr_check: assert property (@(posedge clk) disable iff (!nrst)
        mem_req_valid |-> (mem_req_addr == exp_mem_addr))
        else log_mismatch("mem_req_addr", 32'(mem_req_addr), 32'(exp_mem_addr));
    wb_data_check: assert property (@(posedge clk) disable iff (!nrst)
        (mem_req_valid && (mem_req_op == MEM_WRITE_BACK)) |-> (mem_req_wdata == exp_wb_data))
        else log_mismatch("mem_req_wdata", mem_req_wdata, exp_wb_data);
    miss_req_count: assert property (@(posedge clk) disable iff (!nrst)
        (resp_valid && !exp_hit) |-> (mem_seq == (exp_dirty ? 2 : 1)))
        else log_mismatch("mem_seq", 32'(mem_seq), exp_dirty ? 32'd2 : 32'd1);
    credit_limit: assert property (@(posedge clk) disable iff (!nrst)
        outstanding <= 2)
        else report_failure("more than 2 L2 requests in flight");

    // called on a rising edge and returns on the edge that ends the response
    task automatic access(input cpu_op_t op, input logic [TAG_W-1:0] tag,
                          input logic [INDEX_W-1:0] idx, input logic [31:0] wdata);
        logic [MEM_ADDR_W-1:0] line;
        logic                  hit;
        logic                  victim_dirty;
        line         = {tag, idx};
        hit          = line_valid[idx] && (line_tag[idx] == tag);
        victim_dirty = !hit && line_valid[idx] && line_dirty[idx];
        exp_hit     <= hit;
        exp_dirty   <= victim_dirty;
        exp_line    <= line;
        exp_wb_addr <= {line_tag[idx], idx};
        exp_wb_data <= line_data[idx];
        if (victim_dirty)
            l2_exp[{line_tag[idx], idx}] = line_data[idx];
        if (!hit)
        begin
            line_valid[idx] = 1'b1;
            line_dirty[idx] = 1'b0;
            line_tag[idx]   = tag;
            line_data[idx]  = l2_exp.exists(line) ? l2_exp[line] : fill_word(line);
        end
        if (op == CPU_WRITE)
        begin
            line_data[idx]  = wdata;
            line_dirty[idx] = 1'b1;
        end
        exp_rdata <= line_data[idx];
        issued++;
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= {6'b0, line};
        req_wdata <= wdata;
        @(negedge clk);
        while (stall)
            @(negedge clk);
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        while (!resp_valid)
            @(negedge clk);
        @(posedge clk);
    endtask

    // dirty lines are dropped, not written back
    task automatic flush_all;
        flush <= 1'b1;
        @(posedge clk);
        flush      <= 1'b0;
        line_valid = '0;
        line_dirty = '0;
        @(posedge clk);
    endtask

    initial
    begin
        clk         = 1'b0;
        nrst        = 1'b0;
        req_valid   = 1'b0;
        req_op      = CPU_READ;
        req_addr    = '0;
        req_wdata   = '0;
        flush       = 1'b0;
        err_count   = 0;
        issued      = 0;
        exp_hit     = 1'b0;
        exp_dirty   = 1'b0;
        exp_line    = '0;
        exp_wb_addr = '0;
        exp_wb_data = '0;
        exp_rdata   = '0;
        line_valid  = '0;
        line_dirty  = '0;
        for (int i = 0; i < 64; i++)
        begin
            line_tag[i]  = '0;
            line_data[i] = '0;
        end
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        repeat (4) @(posedge clk);

        // read miss, then hit
        access(CPU_READ, 20'h00001, 6'd3, 32'h0);
        access(CPU_READ, 20'h00001, 6'd3, 32'h0);
        // write hit, read back
        access(CPU_WRITE, 20'h00001, 6'd3, 32'hcafe_0001);
        access(CPU_READ, 20'h00001, 6'd3, 32'h0);
        // dirty victim then reload of the written-back word
        access(CPU_READ, 20'h00002, 6'd3, 32'h0);
        access(CPU_READ, 20'h00001, 6'd3, 32'h0);

        // conflicting misses back to back
        for (int i = 0; i < 24; i++)
            access((i % 3 == 2) ? CPU_READ : CPU_WRITE, 20'(16 + i % 5), 6'(i % 4),
                   32'h5000_0000 + 32'(i));

        access(CPU_READ, 20'h00007, 6'd9, 32'h0);
        access(CPU_READ, 20'h00007, 6'd9, 32'h0);
        flush_all();
        access(CPU_READ, 20'h00007, 6'd9, 32'h0);
        access(CPU_READ, 20'h00010, 6'd0, 32'h0);

        repeat (10) @(posedge clk);
        $display("errors: %0d", err_count);
        if (err_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // 200 cycles per issued request
    initial
    begin
        wd_cycles = 0;
        while (wd_cycles < 200 * (issued + 1))
        begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("timeout: no response after %0d cycles", wd_cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule
